/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    // Memory operation carried by an execute bundle.
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_e;

    // Results offered by the execute stage.
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu_out;      // Address for loads and stores.
        logic [XLEN-1:0] rs2_data;
        mem_op_e         mem_op;
        logic            br_flg;
        logic [XLEN-1:0] br_target;
        logic            jmp_flg;
        logic            rf_wen;
        logic [3:0]      wb_sel;
        logic [4:0]      wb_addr;
        logic            is_ecall;
    } exec_bundle_t;

    // Bundle handed on to write-back.
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu_out;
        logic            br_flg;
        logic [XLEN-1:0] br_target;
        logic            jmp_flg;
        logic            rf_wen;
        logic [3:0]      wb_sel;
        logic [4:0]      wb_addr;
        logic            is_ecall;
        logic [XLEN-1:0] read_data;    // Extended load data, zero otherwise.
    } wb_bundle_t;

endpackage

`default_nettype wire

/* design/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // ==============================
    // Request and response channels
    // ==============================

    // One byte enable per lane of the data word.
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   byte_en;
    } mem_req_t;

    // Only reads get a response.
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  core_pkg::exec_bundle_t in_data,
    output logic                  req_valid,
    input  logic                  req_ready,
    output mem_bus_pkg::mem_req_t req_data,
    input  logic                  rsp_valid,
    output logic                  rsp_ready,
    input  mem_bus_pkg::mem_rsp_t rsp_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output core_pkg::wb_bundle_t  out_data
);
    import core_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_rsp
    } state_e;

    state_e          state;
    exec_bundle_t    held;          // Memory operation in flight.
    logic [1:0]      lane;
    logic            held_store;
    logic            in_fire;
    logic            mem_accept;
    logic            req_fire;
    logic            rsp_fire;
    logic            out_load;
    wb_bundle_t      out_next;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [XLEN-1:0] load_data;

    function automatic wb_bundle_t to_wb(exec_bundle_t b, logic [XLEN-1:0] rd);
        wb_bundle_t w;
        w.pc        = b.pc;
        w.alu_out   = b.alu_out;
        w.br_flg    = b.br_flg;
        w.br_target = b.br_target;
        w.jmp_flg   = b.jmp_flg;
        w.rf_wen    = b.rf_wen;
        w.wb_sel    = b.wb_sel;
        w.wb_addr   = b.wb_addr;
        w.is_ecall  = b.is_ecall;
        w.read_data = rd;
        return w;
    endfunction

    // ==============================
    // Handshakes and control
    // ==============================

    // Take a new item only when nothing is pending and the output can move.
    assign in_ready   = (state == st_idle) && (!out_valid || out_ready);
    assign req_valid  = (state == st_req);
    assign rsp_ready  = (state == st_wait_rsp);

    assign in_fire    = in_valid && in_ready;
    assign req_fire   = req_valid && req_ready;
    assign rsp_fire   = rsp_valid && rsp_ready;
    assign mem_accept = in_fire && !flush && (in_data.mem_op != mem_none);

    assign lane       = held.alu_out[1:0];
    assign held_store = held.mem_op inside {mem_sb, mem_sh, mem_sw};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (mem_accept) state <= st_req;
                end
                st_req: begin
                    if (req_fire) state <= held_store ? st_idle : st_wait_rsp;
                end
                st_wait_rsp: begin
                    if (rsp_fire) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_accept) begin
            held <= in_data;
        end
    end

    // ==============================
    // Request formation
    // ==============================

    always_comb begin
        req_data.write = held_store;
        req_data.addr  = held.alu_out;
        case (held.mem_op)
            mem_lb, mem_lbu, mem_sb: begin
                req_data.byte_en = BE_W'(1) << lane;
                req_data.wdata   = {24'b0, held.rs2_data[7:0]} << (8 * lane);
            end
            mem_lh, mem_lhu, mem_sh: begin
                req_data.byte_en = lane[1] ? 4'b1100 : 4'b0011;  // Bit 0 is ignored.
                req_data.wdata   = {16'b0, held.rs2_data[15:0]} << (16 * lane[1]);
            end
            default: begin
                req_data.byte_en = {BE_W{1'b1}};
                req_data.wdata   = held.rs2_data;
            end
        endcase
    end

    // ==============================
    // Load extension and output
    // ==============================

    always_comb begin
        byte_sel = rsp_data.rdata[8*lane +: 8];
        half_sel = rsp_data.rdata[16*lane[1] +: 16];
        case (held.mem_op)
            mem_lb:  load_data = {{24{byte_sel[7]}}, byte_sel};
            mem_lbu: load_data = {24'b0, byte_sel};
            mem_lh:  load_data = {{16{half_sel[15]}}, half_sel};
            mem_lhu: load_data = {16'b0, half_sel};
            default: load_data = rsp_data.rdata;
        endcase
    end

    // At most one of these fires in a cycle, as each belongs to one state.
    always_comb begin
        out_load = 1'b0;
        out_next = to_wb(held, '0);
        if (in_fire && !flush && (in_data.mem_op == mem_none)) begin
            out_load = 1'b1;
            out_next = to_wb(in_data, '0);
        end else if (req_fire && held_store) begin
            out_load = 1'b1;
        end else if (rsp_fire) begin
            out_load = 1'b1;
            out_next = to_wb(held, load_data);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (out_load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= out_next;
        end
    end

endmodule

`default_nettype wire

/* design/stream_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
    parameter int  FIFO_DEPTH = 2,
    parameter type payload_t  = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Pointers wrap on their own since the depth is a power of two.
    if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
        $error("stream_fifo depth must be a power of two of at least 2");
    end

    payload_t         entries [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = entries[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_bus_pkg::mem_req_t req_data,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output mem_bus_pkg::mem_rsp_t rsp_data
);
    import mem_bus_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  word_idx;
    logic              req_fire;
    logic              wr_fire;
    logic              rd_fire;

    // Upper address bits are dropped, so accesses wrap around the array.
    assign word_idx = req_data.addr[2 +: IDX_W];

    // Writes always go through. A read needs room in the response register.
    assign req_ready = req_data.write || !rsp_valid || rsp_ready;

    assign req_fire = req_valid && req_ready;
    assign wr_fire  = req_fire && req_data.write;
    assign rd_fire  = req_fire && !req_data.write;

    // ==============================
    // Word array
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < BE_W; b++) begin
                if (req_data.byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= req_data.wdata[8*b +: 8];
                end
            end
        end
    end

    // ==============================
    // Read response
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data.rdata <= mem[word_idx];  // Held until the response drains.
        end
    end

endmodule

`default_nettype wire

/* design/mem_subsystem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top #(
    parameter int FIFO_DEPTH = 2,
    parameter int RAM_WORDS  = 256
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  core_pkg::exec_bundle_t in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output core_pkg::wb_bundle_t   out_data
);
    import mem_bus_pkg::*;

    // Stage to request FIFO.
    logic     stage_req_valid;
    logic     stage_req_ready;
    mem_req_t stage_req_data;

    // Request FIFO to RAM.
    logic     ram_req_valid;
    logic     ram_req_ready;
    mem_req_t ram_req_data;

    // RAM to response FIFO.
    logic     ram_rsp_valid;
    logic     ram_rsp_ready;
    mem_rsp_t ram_rsp_data;

    // Response FIFO back to the stage.
    logic     stage_rsp_valid;
    logic     stage_rsp_ready;
    mem_rsp_t stage_rsp_data;

    mem_stage u_mem_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .req_valid (stage_req_valid),
        .req_ready (stage_req_ready),
        .req_data  (stage_req_data),
        .rsp_valid (stage_rsp_valid),
        .rsp_ready (stage_rsp_ready),
        .rsp_data  (stage_rsp_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (mem_req_t)
    ) u_req_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (stage_req_valid),
        .in_ready  (stage_req_ready),
        .in_data   (stage_req_data),
        .out_valid (ram_req_valid),
        .out_ready (ram_req_ready),
        .out_data  (ram_req_data)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (ram_req_valid),
        .req_ready (ram_req_ready),
        .req_data  (ram_req_data),
        .rsp_valid (ram_rsp_valid),
        .rsp_ready (ram_rsp_ready),
        .rsp_data  (ram_rsp_data)
    );

    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (mem_rsp_t)
    ) u_rsp_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (ram_rsp_valid),
        .in_ready  (ram_rsp_ready),
        .in_data   (ram_rsp_data),
        .out_valid (stage_rsp_valid),
        .out_ready (stage_rsp_ready),
        .out_data  (stage_rsp_data)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;    // Released on a clock edge.
    end

endmodule

`default_nettype wire

/* tests/mem_subsystem_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_properties (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   in_valid,
    input logic                   in_ready,
    input core_pkg::exec_bundle_t in_data,
    input logic                   out_valid,
    input logic                   out_ready,
    input core_pkg::wb_bundle_t   out_data,
    input logic                   req_valid,
    input logic                   req_ready,
    input mem_bus_pkg::mem_req_t  req_data,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input logic                   ram_rsp_valid
);

    logic load_pending;    // A read request left the stage and has not been answered.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_pending <= 1'b0;
        end else if (req_valid && req_ready && !req_data.write) begin
            load_pending <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            load_pending <= 1'b0;
        end
    end

    // ==============================
    // Handshake stability
    // ==============================

    a_in_stable: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("input channel changed before it was accepted");

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output channel changed before it was accepted");

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req_data))
        else $error("request channel changed before it was accepted");

    a_reset_out: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid is high during reset");

    a_rsp_needs_load: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid || ram_rsp_valid) |-> load_pending)
        else $error("a read response appeared with no load outstanding");

endmodule

bind mem_subsystem_top mem_subsystem_properties u_properties (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_data       (in_data),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_data      (out_data),
    .req_valid     (stage_req_valid),
    .req_ready     (stage_req_ready),
    .req_data      (stage_req_data),
    .rsp_valid     (stage_rsp_valid),
    .rsp_ready     (stage_rsp_ready),
    .ram_rsp_valid (ram_rsp_valid)
);

`default_nettype wire

/* tests/mem_subsystem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_tb;
    import core_pkg::*;

    localparam int N_ITEMS    = 2000;
    localparam int MAX_CYCLES = N_ITEMS * 20;
    localparam int N_ZERO     = 32;    // Leading loads that read untouched memory.

    logic         clk;
    logic         arst_n;
    logic         flush;
    logic         in_valid;
    logic         in_ready;
    exec_bundle_t in_data;
    logic         out_valid;
    logic         out_ready;
    wb_bundle_t   out_data;

    logic [31:0]  rng;
    logic [31:0]  model_mem [64];
    wb_bundle_t   expected_q [$];
    int           n_sent;
    int           n_expected;
    int           n_out;
    int           errors;
    int           cycles;
    logic         timed_out;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(16)) u_clock (.clk(clk), .arst_n(arst_n));

    mem_subsystem_top #(.FIFO_DEPTH(2), .RAM_WORDS(256)) dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // ==============================
    // Stimulus and reference model
    // ==============================

    task automatic drive_next_item();
        exec_bundle_t b;
        logic [159:0] raw;
        logic [31:0]  r;
        logic [3:0]   op;
        raw = {rand_word(), rand_word(), rand_word(), rand_word(), rand_word()};
        b   = raw[$bits(exec_bundle_t)-1:0];
        r   = rand_word();
        op  = 4'(r[15:0] % 9);
        if (n_sent < N_ZERO) op = r[8] ? mem_lw : mem_lbu;
        b.mem_op = mem_op_e'(op);
        if (b.mem_op != mem_none) b.alu_out = {24'b0, r[23:16]};  // 64 words.
        flush    <= (r[31:28] == 4'd0) && (n_sent >= N_ZERO);
        in_data  <= b;
        in_valid <= 1'b1;
    endtask

    task automatic accept_item(input exec_bundle_t b, input logic flushed);
        wb_bundle_t  w;
        logic [5:0]  idx;
        logic [1:0]  lane;
        logic [31:0] word;
        logic [7:0]  bsel;
        logic [15:0] hsel;
        n_sent++;
        if (flushed) return;
        idx  = b.alu_out[7:2];
        lane = b.alu_out[1:0];
        word = model_mem[idx];
        bsel = word[8*lane +: 8];
        hsel = word[16*lane[1] +: 16];
        w = '{pc: b.pc, alu_out: b.alu_out, br_flg: b.br_flg, br_target: b.br_target,
              jmp_flg: b.jmp_flg, rf_wen: b.rf_wen, wb_sel: b.wb_sel,
              wb_addr: b.wb_addr, is_ecall: b.is_ecall, read_data: 32'b0};
        case (b.mem_op)
            mem_lb:  w.read_data = {{24{bsel[7]}}, bsel};
            mem_lbu: w.read_data = {24'b0, bsel};
            mem_lh:  w.read_data = {{16{hsel[15]}}, hsel};
            mem_lhu: w.read_data = {16'b0, hsel};
            mem_lw:  w.read_data = word;
            mem_sb:  model_mem[idx][8*lane +: 8] = b.rs2_data[7:0];
            mem_sh:  model_mem[idx][16*lane[1] +: 16] = b.rs2_data[15:0];
            mem_sw:  model_mem[idx] = b.rs2_data;
            default: ;
        endcase
        expected_q.push_back(w);
        n_expected++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t out_data.%s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_output(input wb_bundle_t got);
        wb_bundle_t exp;
        n_out++;
        if (expected_q.size() == 0) begin
            $display("ERROR at %0t: an output arrived when no item was expected", $time);
            errors++;
            return;
        end
        exp = expected_q.pop_front();
        compare_field("pc", got.pc, exp.pc);
        compare_field("alu_out", got.alu_out, exp.alu_out);
        compare_field("br_flg", 32'(got.br_flg), 32'(exp.br_flg));
        compare_field("br_target", got.br_target, exp.br_target);
        compare_field("jmp_flg", 32'(got.jmp_flg), 32'(exp.jmp_flg));
        compare_field("rf_wen", 32'(got.rf_wen), 32'(exp.rf_wen));
        compare_field("wb_sel", 32'(got.wb_sel), 32'(exp.wb_sel));
        compare_field("wb_addr", 32'(got.wb_addr), 32'(exp.wb_addr));
        compare_field("is_ecall", 32'(got.is_ecall), 32'(exp.is_ecall));
        compare_field("read_data", got.read_data, exp.read_data);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            if (out_valid !== 1'b0) begin
                $display("ERROR t=%0t out_valid got %b expected 0", $time, out_valid);
                errors++;
            end
        end else begin
            cycles++;
            if (out_valid && out_ready) check_output(out_data);
            if (in_valid && in_ready) begin
                accept_item(in_data, flush);
                in_valid <= 1'b0;
            end
            if ((!in_valid || in_ready) && n_sent < N_ITEMS) drive_next_item();
            out_ready <= (rand_word() & 32'h3) != 32'h0;    // Low about 1 cycle in 4.
        end
    end

    // ==============================
    // Run control
    // ==============================

    initial begin
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b0;
        rng        = 32'hb5b1;
        n_sent     = 0;
        n_expected = 0;
        n_out      = 0;
        errors     = 0;
        cycles     = 0;
        for (int i = 0; i < 64; i++) model_mem[i] = '0;
        wait (arst_n === 1'b1);
        while (!(n_sent == N_ITEMS && expected_q.size() == 0) && cycles < MAX_CYCLES) begin
            @(negedge clk);
        end
        timed_out = !(n_sent == N_ITEMS && expected_q.size() == 0);
        if (timed_out) begin
            $display("Timeout: the DUT stopped moving items after %0d cycles", cycles);
        end
        if (n_out != n_expected) begin
            $display("Output count %0d does not match %0d unflushed items", n_out, n_expected);
            errors++;
        end
        $display("Items %0d, outputs %0d, expected %0d, errors %0d",
                 n_sent, n_out, n_expected, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/core_pkg.sv
design/mem_bus_pkg.sv
design/mem_stage.sv
design/stream_fifo.sv
design/data_ram.sv
design/mem_subsystem_top.sv
tests/tb_clock.sv
tests/mem_subsystem_properties.sv
tests/mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - design/core_pkg.sv
  - design/mem_bus_pkg.sv
  - design/mem_stage.sv
  - design/stream_fifo.sv
  - design/data_ram.sv
  - design/mem_subsystem_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/mem_subsystem_properties.sv
      - tests/mem_subsystem_tb.sv
